// ==== compile.f ====
+incdir+sim
hw/afu_pkg.sv
hw/local_mem.sv
hw/mmio_csr.sv
hw/dma_copy_engine.sv
hw/afu.sv
sim/tb_afu.sv

// ==== Makefile ====
# tool and options
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_afu
FILELIST  = compile.f
OBJDIR    = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sim/afu_tb_ref.svh ====
// afu testbench reference model

// shadow copies of both banks
afu_pkg::t_mmio_data shadow_a [];
afu_pkg::t_mmio_data shadow_b [];

int check_count = 0;
int error_count = 0;

// copy len words a to b, both indices wrap at the bank end
function automatic void ref_copy(input int src, input int dst, input int len);
	for (int i = 0; i < len; i++)
		shadow_b[(dst + i) % afu_pkg::MEM_DEPTH] = shadow_a[(src + i) % afu_pkg::MEM_DEPTH];
endfunction

// sum mod 2^64 of the words a copy moves
function automatic afu_pkg::t_mmio_data ref_checksum(input int src, input int len);
	afu_pkg::t_mmio_data sum;
	sum = '0;
	for (int i = 0; i < len; i++)
		sum = sum + shadow_a[(src + i) % afu_pkg::MEM_DEPTH];  // wraps naturally
	return sum;
endfunction

// ctrl write sampling edge to dma_done, in cycles
function automatic int ref_done_delay(input int len);
	return (len == 0) ? 1 : len + 3;
endfunction

function automatic void report_failure(input string msg);
	error_count++;
	$display("error at %0t ns: %s", $time, msg);
endfunction

task automatic check_value(input afu_pkg::t_mmio_data got, input afu_pkg::t_mmio_data exp,
	input string msg);
	check_count++;
	if (got !== exp) begin  // x counts as wrong
		error_count++;
		$display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
	end
endtask

// ==== sim/tb_afu.sv ====
// afu testbench top
`timescale 1ns/1ps
module tb_afu;

	localparam int NUM_TESTS       = 10;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (256 + 50) + 20;
	localparam int DONE_TIMEOUT    = 300;  // cycles
	localparam afu_pkg::t_mmio_addr UNMAPPED_LO = 18'h00100;  // between csrs and window a
	localparam afu_pkg::t_mmio_addr UNMAPPED_HI = 18'h3ff00;

	logic                Clk_400;
	logic                reset;
	logic                mmio_wr_valid;
	logic                mmio_rd_valid;
	afu_pkg::t_mmio_addr mmio_addr;
	afu_pkg::t_mmio_data mmio_wr_data;
	logic                mmio_rd_rsp_valid;
	afu_pkg::t_mmio_data mmio_rd_rsp_data;
	logic                dma_done;

	int   cycle = 0;            // rising edges so far
	int   done_count = 0;
	int   last_done_cycle = 0;
	logic done_prev = 1'b0;
	int   test_count = 0;
	int   test_err_start = 0;

	// burst read address list and captured responses
	afu_pkg::t_mmio_addr rd_addr_buf [];
	afu_pkg::t_mmio_data rd_data_buf [];

	`include "afu_tb_ref.svh"

	afu i_dut (
		.Clk_400, .reset,
		.mmio_wr_valid, .mmio_rd_valid, .mmio_addr, .mmio_wr_data,
		.mmio_rd_rsp_valid, .mmio_rd_rsp_data,
		.dma_done
	);

	initial begin
		Clk_400 = 1'b0;
		forever #50 Clk_400 = ~Clk_400;  // 100 ns period
	end

	always @(posedge Clk_400)
		cycle <= cycle + 1;

	// dma_done monitor, sampled mid cycle
	always @(negedge Clk_400) begin
		if (dma_done === 1'b1) begin
			done_count++;
			last_done_cycle = cycle;
			if (done_prev)
				report_failure("dma_done stayed high for more than one cycle");
		end
		done_prev = (dma_done === 1'b1);
	end

	// **************************************************
	// driver tasks, all start and end 10 ns after an edge
	// **************************************************
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge Clk_400);
			#10;
		end
	endtask

	function automatic afu_pkg::t_mmio_data rand_word();
		return {$urandom, $urandom};
	endfunction

	task automatic mmio_write(input afu_pkg::t_mmio_addr addr, input afu_pkg::t_mmio_data data);
		mmio_wr_valid = 1'b1;
		mmio_addr     = addr;
		mmio_wr_data  = data;
		idle_cycles(1);  // sampled here
		mmio_wr_valid = 1'b0;
	endtask

	// back to back reads of rd_addr_buf, response due 4 steps after the drive
	task automatic mmio_read_burst(input int n);
		logic exp_valid;
		for (int s = 0; s <= n + 4; s++) begin
			exp_valid = (s >= 4) && (s - 4 < n);
			check_value(afu_pkg::t_mmio_data'(mmio_rd_rsp_valid),
				afu_pkg::t_mmio_data'(exp_valid), "read response valid");
			if (exp_valid)
				rd_data_buf[s - 4] = mmio_rd_rsp_data;
			mmio_rd_valid = (s < n);
			if (s < n)
				mmio_addr = rd_addr_buf[s];
			idle_cycles(1);
		end
	endtask

	task automatic mmio_read(input afu_pkg::t_mmio_addr addr, output afu_pkg::t_mmio_data data);
		rd_addr_buf[0] = addr;
		mmio_read_burst(1);
		data = rd_data_buf[0];
	endtask

	task automatic fill_bank(input afu_pkg::t_mmio_addr base, input bit to_b);
		afu_pkg::t_mmio_data w;
		for (int i = 0; i < afu_pkg::MEM_DEPTH; i++) begin
			w = rand_word();
			if (to_b)
				shadow_b[i] = w;
			else
				shadow_a[i] = w;
			mmio_write(afu_pkg::t_mmio_addr'(base + i), w);
		end
	endtask

	// whole bank against its shadow, one read per cycle
	task automatic check_bank(input afu_pkg::t_mmio_addr base, input bit from_b, input string name);
		afu_pkg::t_mmio_data exp;
		for (int i = 0; i < afu_pkg::MEM_DEPTH; i++)
			rd_addr_buf[i] = afu_pkg::t_mmio_addr'(base + i);
		mmio_read_burst(afu_pkg::MEM_DEPTH);
		for (int i = 0; i < afu_pkg::MEM_DEPTH; i++) begin
			exp = from_b ? shadow_b[i] : shadow_a[i];
			check_value(rd_data_buf[i], exp, $sformatf("%s word %0d", name, i));
		end
	endtask

	task automatic wait_done(input int c0, input int exp_delay, input int exp_count);
		int waited;
		waited = 0;
		while (done_count < exp_count && waited < DONE_TIMEOUT) begin
			idle_cycles(1);
			waited++;
		end
		if (done_count < exp_count)
			report_failure("dma_done never arrived after the start write");
		else
			check_value(afu_pkg::t_mmio_data'(last_done_cycle - c0),
				afu_pkg::t_mmio_data'(exp_delay), "start to dma_done cycles");
		idle_cycles(4);  // room for a stray second pulse
		check_value(afu_pkg::t_mmio_data'(done_count), afu_pkg::t_mmio_data'(exp_count),
			"dma_done pulse count");
	endtask

	task automatic run_copy(input int src, input int dst, input int len, input bit extra_starts);
		int                  c0;
		int                  done_before;
		afu_pkg::t_mmio_data rdata;
		afu_pkg::t_mmio_data exp_sum;
		mmio_write(afu_pkg::CSR_SRC, afu_pkg::t_mmio_data'(src));
		mmio_write(afu_pkg::CSR_DST, afu_pkg::t_mmio_data'(dst));
		mmio_write(afu_pkg::CSR_LEN, afu_pkg::t_mmio_data'(len));
		done_before = done_count;
		mmio_write(afu_pkg::CSR_CTRL, 64'h1);
		c0 = cycle;  // edge that sampled the start
		if (extra_starts) begin
			mmio_write(afu_pkg::CSR_CTRL, 64'h1);  // while start is still high
			idle_cycles(2);
			mmio_write(afu_pkg::CSR_CTRL, 64'h1);  // engine busy
		end
		wait_done(c0, ref_done_delay(len), done_before + 1);
		exp_sum = ref_checksum(src, len);
		ref_copy(src, dst, len);
		mmio_read(afu_pkg::CSR_CHECKSUM, rdata);
		check_value(rdata, exp_sum, "copy checksum");
		mmio_read(afu_pkg::CSR_STATUS, rdata);
		check_value(rdata, 64'h2, "status after copy");  // busy low, done set
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %-18s %0d errors", test_count, name, error_count - test_err_start);
		test_err_start = error_count;
	endtask

	// **************************************************
	// test sequence
	// **************************************************
	initial begin
		afu_pkg::t_mmio_data src_w;
		afu_pkg::t_mmio_data dst_w;
		afu_pkg::t_mmio_data len_w;
		int                  src;
		int                  dst;
		int                  len;
		void'($urandom(28));
		shadow_a      = new[afu_pkg::MEM_DEPTH];
		shadow_b      = new[afu_pkg::MEM_DEPTH];
		rd_addr_buf   = new[afu_pkg::MEM_DEPTH];
		rd_data_buf   = new[afu_pkg::MEM_DEPTH];
		reset         = 1'b1;
		mmio_wr_valid = 1'b0;
		mmio_rd_valid = 1'b0;
		mmio_addr     = '0;
		mmio_wr_data  = '0;
		repeat (5) @(posedge Clk_400);
		#10 reset = 1'b0;

		idle_cycles(3);
		check_value(afu_pkg::t_mmio_data'(done_count), 64'd0, "dma_done after reset");
		rd_addr_buf[0] = afu_pkg::CSR_STATUS;
		rd_addr_buf[1] = afu_pkg::CSR_CHECKSUM;
		rd_addr_buf[2] = afu_pkg::CSR_SRC;
		rd_addr_buf[3] = afu_pkg::CSR_DST;
		rd_addr_buf[4] = afu_pkg::CSR_LEN;
		mmio_read_burst(5);
		for (int i = 0; i < 5; i++)
			check_value(rd_data_buf[i], 64'd0, $sformatf("csr %0d after reset", i));
		finish_test("reset_state");

		src_w = rand_word();
		dst_w = rand_word();
		len_w = rand_word();
		mmio_write(afu_pkg::CSR_SRC, src_w);
		mmio_write(afu_pkg::CSR_DST, dst_w);
		mmio_write(afu_pkg::CSR_LEN, len_w);
		mmio_write(UNMAPPED_LO, rand_word());  // dropped by the decoder
		rd_addr_buf[0] = afu_pkg::CSR_SRC;
		rd_addr_buf[1] = afu_pkg::CSR_DST;
		rd_addr_buf[2] = afu_pkg::CSR_LEN;
		rd_addr_buf[3] = UNMAPPED_LO;
		rd_addr_buf[4] = UNMAPPED_HI;
		mmio_read_burst(5);
		check_value(rd_data_buf[0], afu_pkg::t_mmio_data'(src_w[7:0]), "src readback");
		check_value(rd_data_buf[1], afu_pkg::t_mmio_data'(dst_w[7:0]), "dst readback");
		check_value(rd_data_buf[2], afu_pkg::t_mmio_data'(len_w[8:0]), "len readback");
		check_value(rd_data_buf[3], 64'd0, "unmapped low read");
		check_value(rd_data_buf[4], 64'd0, "unmapped high read");
		finish_test("csr_readback");

		fill_bank(afu_pkg::WIN_A_BASE, 1'b0);
		check_bank(afu_pkg::WIN_A_BASE, 1'b0, "bank a");
		finish_test("window_a");
		fill_bank(afu_pkg::WIN_B_BASE, 1'b1);
		check_bank(afu_pkg::WIN_B_BASE, 1'b1, "bank b");
		finish_test("window_b");

		for (int k = 0; k < 4; k++) begin
			src = $urandom % 256;
			dst = $urandom % 256;
			len = 1 + $urandom % 64;
			if (k == 0) begin  // source wraps past word 255
				src = 250;
				len = 16 + $urandom % 49;
			end
			if (k == 1) begin  // destination wraps
				dst = 245;
				len = 16 + $urandom % 49;
			end
			run_copy(src, dst, len, 1'b0);
			check_bank(afu_pkg::WIN_B_BASE, 1'b1, "bank b");
			finish_test($sformatf("copy_%0d", k));
		end

		run_copy($urandom % 256, $urandom % 256, 0, 1'b0);
		finish_test("zero_length");

		len = 16 + $urandom % 49;  // long enough to still be busy
		run_copy($urandom % 256, $urandom % 256, len, 1'b1);
		check_bank(afu_pkg::WIN_B_BASE, 1'b1, "bank b");
		finish_test("start_while_busy");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge Clk_400);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== hw/afu.sv ====
`timescale 1ns/1ps
// accelerator function unit top
module afu (
	input  logic                Clk_400,
	input  logic                reset,
	// host mmio
	input  logic                mmio_wr_valid,
	input  logic                mmio_rd_valid,
	input  afu_pkg::t_mmio_addr mmio_addr,
	input  afu_pkg::t_mmio_data mmio_wr_data,
	output logic                mmio_rd_rsp_valid,
	output afu_pkg::t_mmio_data mmio_rd_rsp_data,
	output logic                dma_done  // copy finished strobe
);

	// host port, shared by both banks
	logic                mem_a_rd;
	logic                mem_a_wr;
	logic                mem_b_rd;
	logic                mem_b_wr;
	afu_pkg::t_mem_addr  mem_index;
	afu_pkg::t_mmio_data mem_wr_data;
	afu_pkg::t_mmio_data mem_a_rd_data;
	afu_pkg::t_mmio_data mem_b_rd_data;

	// csr to engine
	logic                start;
	afu_pkg::t_mem_addr  src_index;
	afu_pkg::t_mem_addr  dst_index;
	afu_pkg::t_dma_len   length;
	logic                busy;
	afu_pkg::t_mmio_data checksum;

	// engine to banks
	logic                dma_rd;
	afu_pkg::t_mem_addr  dma_rd_index;
	afu_pkg::t_mmio_data dma_rd_data;
	logic                dma_wr;
	afu_pkg::t_mem_addr  dma_wr_index;
	afu_pkg::t_mmio_data dma_wr_data;

	mmio_csr mmio_csr_inst (
		.Clk_400, .reset,
		.mmio_wr_valid, .mmio_rd_valid, .mmio_addr, .mmio_wr_data,
		.mmio_rd_rsp_valid, .mmio_rd_rsp_data,
		.mem_a_rd, .mem_a_wr, .mem_b_rd, .mem_b_wr,
		.mem_index, .mem_wr_data, .mem_a_rd_data, .mem_b_rd_data,
		.start, .src_index, .dst_index, .length,
		.busy, .done(dma_done), .checksum
	);

	dma_copy_engine dma_copy_engine_inst (
		.Clk_400, .reset,
		.start, .src_index, .dst_index, .length,
		.rd(dma_rd), .rd_index(dma_rd_index), .rd_data(dma_rd_data),
		.wr(dma_wr), .wr_index(dma_wr_index), .wr_data(dma_wr_data),
		.busy, .done(dma_done), .checksum
	);

	// bank a, port b is the engine read port
	local_mem mem_a_inst (
		.Clk_400, .reset,
		.a_rd(mem_a_rd), .a_wr(mem_a_wr), .a_index(mem_index),
		.a_wr_data(mem_wr_data), .a_rd_data(mem_a_rd_data),
		.b_rd(dma_rd), .b_wr(1'b0), .b_index(dma_rd_index),
		.b_wr_data('0), .b_rd_data(dma_rd_data)
	);

	// bank b, port b is the engine write port
	local_mem mem_b_inst (
		.Clk_400, .reset,
		.a_rd(mem_b_rd), .a_wr(mem_b_wr), .a_index(mem_index),
		.a_wr_data(mem_wr_data), .a_rd_data(mem_b_rd_data),
		.b_rd(1'b0), .b_wr(dma_wr), .b_index(dma_wr_index),
		.b_wr_data(dma_wr_data), .b_rd_data()
	);

endmodule

// ==== hw/dma_copy_engine.sv ====
`timescale 1ns/1ps
// bank a to bank b copy engine
module dma_copy_engine (
	input  logic                Clk_400,
	input  logic                reset,
	// control from csr block
	input  logic                start,
	input  afu_pkg::t_mem_addr  src_index,
	input  afu_pkg::t_mem_addr  dst_index,
	input  afu_pkg::t_dma_len   length,
	// bank a read port
	output logic                rd,
	output afu_pkg::t_mem_addr  rd_index,
	input  afu_pkg::t_mmio_data rd_data,
	// bank b write port
	output logic                wr,
	output afu_pkg::t_mem_addr  wr_index,
	output afu_pkg::t_mmio_data wr_data,
	// status
	output logic                busy,
	output logic                done,
	output afu_pkg::t_mmio_data checksum
);

	localparam int LAT = afu_pkg::MEM_LATENCY;

	afu_pkg::t_dma_state state;
	afu_pkg::t_mem_addr  src_q;   // copy parameters, latched at start
	afu_pkg::t_mem_addr  dst_q;
	afu_pkg::t_dma_len   len_q;
	afu_pkg::t_dma_len   rd_cnt;  // reads issued so far
	logic                rd_last;
	logic                drain_end;
	logic                done_q;
	afu_pkg::t_mmio_data sum_q;

	// returns in flight, bit 0 newest
	logic [LAT-1:0]      vld_pipe;
	afu_pkg::t_mem_addr  dst_pipe [LAT];

	// **************************************************
	// read side
	// **************************************************
	assign rd       = (state == afu_pkg::DMA_RUN);  // one read per run cycle
	assign rd_index = src_q + rd_cnt[7:0];           // wraps mod 256
	assign rd_last  = (rd_cnt == len_q - afu_pkg::t_dma_len'(1));

	// oldest slot full, nothing behind it
	assign drain_end = (vld_pipe == {1'b1, {(LAT-1){1'b0}}});

	always_ff @(posedge Clk_400) begin
		if (reset) begin
			state  <= afu_pkg::DMA_IDLE;
			rd_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;  // single cycle pulse
			case (state)
				afu_pkg::DMA_IDLE: begin
					if (start) begin
						rd_cnt <= '0;
						if (length == '0)
							done_q <= 1'b1;  // empty copy, finish at once
						else
							state <= afu_pkg::DMA_RUN;
					end
				end
				afu_pkg::DMA_RUN: begin
					rd_cnt <= rd_cnt + afu_pkg::t_dma_len'(1);
					if (rd_last)
						state <= afu_pkg::DMA_DRAIN;
				end
				afu_pkg::DMA_DRAIN: begin
					if (drain_end) begin  // last word written this cycle
						state  <= afu_pkg::DMA_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= afu_pkg::DMA_IDLE;
			endcase
		end
	end

	// latch so csr writes during a copy do not disturb it
	always_ff @(posedge Clk_400) begin
		if (start && state == afu_pkg::DMA_IDLE) begin
			src_q <= src_index;
			dst_q <= dst_index;
			len_q <= length;
		end
	end

	// **************************************************
	// return side, matched to bank latency
	// **************************************************
	always_ff @(posedge Clk_400) begin
		if (reset)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[LAT-2:0], rd};
	end

	always_ff @(posedge Clk_400) begin
		dst_pipe[0] <= dst_q + rd_cnt[7:0];  // destination for this read
		for (int i = 1; i < LAT; i++)
			dst_pipe[i] <= dst_pipe[i-1];
	end

	assign wr       = vld_pipe[LAT-1];
	assign wr_index = dst_pipe[LAT-1];
	assign wr_data  = rd_data;  // returned word goes straight to bank b

	// checksum, sum mod 2^64 of the words written
	always_ff @(posedge Clk_400) begin
		if (reset)
			sum_q <= '0;
		else if (start && state == afu_pkg::DMA_IDLE)
			sum_q <= '0;
		else if (wr)
			sum_q <= sum_q + rd_data;
	end

	assign busy     = (state != afu_pkg::DMA_IDLE);
	assign done     = done_q;
	assign checksum = sum_q;

	// never a read past the latched copy length
	a_rd_in_len: assert property (@(posedge Clk_400) disable iff (reset)
		rd |-> (rd_cnt < len_q));

	a_done_pulse: assert property (@(posedge Clk_400) disable iff (reset)
		done |=> !done);

endmodule

// ==== hw/mmio_csr.sv ====
`timescale 1ns/1ps
// mmio register and window decode
module mmio_csr (
	input  logic                Clk_400,
	input  logic                reset,
	// host mmio
	input  logic                mmio_wr_valid,
	input  logic                mmio_rd_valid,
	input  afu_pkg::t_mmio_addr mmio_addr,
	input  afu_pkg::t_mmio_data mmio_wr_data,
	output logic                mmio_rd_rsp_valid,
	output afu_pkg::t_mmio_data mmio_rd_rsp_data,
	// host port of both banks
	output logic                mem_a_rd,
	output logic                mem_a_wr,
	output logic                mem_b_rd,
	output logic                mem_b_wr,
	output afu_pkg::t_mem_addr  mem_index,
	output afu_pkg::t_mmio_data mem_wr_data,
	input  afu_pkg::t_mmio_data mem_a_rd_data,
	input  afu_pkg::t_mmio_data mem_b_rd_data,
	// copy engine
	output logic                start,
	output afu_pkg::t_mem_addr  src_index,
	output afu_pkg::t_mem_addr  dst_index,
	output afu_pkg::t_dma_len   length,
	input  logic                busy,
	input  logic                done,
	input  afu_pkg::t_mmio_data checksum
);

	localparam int RD_STAGES = afu_pkg::MMIO_RD_LATENCY;

	logic                win_a_hit;
	logic                win_b_hit;
	logic                done_sticky;  // set by done, cleared by start
	afu_pkg::t_mmio_data csr_rd_val;   // csr value at the read address
	afu_pkg::t_rsp_sel   rd_sel_now;

	// read pipeline, stage 0 loads at the sampling edge
	logic [RD_STAGES-1:0] rd_vld;
	afu_pkg::t_rsp_sel    rd_sel [RD_STAGES];
	afu_pkg::t_mmio_data  rd_csr [RD_STAGES];

	// **************************************************
	// address decode
	// **************************************************
	assign win_a_hit = (mmio_addr[17:8] == afu_pkg::WIN_A_BASE[17:8]);
	assign win_b_hit = (mmio_addr[17:8] == afu_pkg::WIN_B_BASE[17:8]);

	always_comb begin
		rd_sel_now = afu_pkg::RSP_SEL_CSR;  // unmapped falls here too
		if (win_a_hit)
			rd_sel_now = afu_pkg::RSP_SEL_MEM_A;
		else if (win_b_hit)
			rd_sel_now = afu_pkg::RSP_SEL_MEM_B;
	end

	always_comb begin
		case (mmio_addr)
			afu_pkg::CSR_SRC:      csr_rd_val = afu_pkg::t_mmio_data'(src_index);
			afu_pkg::CSR_DST:      csr_rd_val = afu_pkg::t_mmio_data'(dst_index);
			afu_pkg::CSR_LEN:      csr_rd_val = afu_pkg::t_mmio_data'(length);
			afu_pkg::CSR_STATUS:   csr_rd_val = afu_pkg::t_mmio_data'({done_sticky, busy});
			afu_pkg::CSR_CHECKSUM: csr_rd_val = checksum;
			default:               csr_rd_val = '0;  // ctrl is write only
		endcase
	end

	// **************************************************
	// control registers
	// **************************************************
	always_ff @(posedge Clk_400) begin
		if (reset) begin
			src_index <= '0;
			dst_index <= '0;
			length    <= '0;
		end else if (mmio_wr_valid) begin
			case (mmio_addr)
				afu_pkg::CSR_SRC: src_index <= mmio_wr_data[7:0];
				afu_pkg::CSR_DST: dst_index <= mmio_wr_data[7:0];
				afu_pkg::CSR_LEN: length    <= mmio_wr_data[8:0];
				default: ;
			endcase
		end
	end

	// start strobe, dropped while a copy is pending or running
	always_ff @(posedge Clk_400) begin
		if (reset) begin
			start       <= 1'b0;
			done_sticky <= 1'b0;
		end else begin
			start <= mmio_wr_valid && (mmio_addr == afu_pkg::CSR_CTRL) &&
				mmio_wr_data[0] && !busy && !start;
			if (start)
				done_sticky <= 1'b0;
			else if (done)
				done_sticky <= 1'b1;
		end
	end

	// **************************************************
	// bank host port, registered request
	// **************************************************
	always_ff @(posedge Clk_400) begin
		if (reset) begin
			mem_a_rd <= 1'b0;
			mem_a_wr <= 1'b0;
			mem_b_rd <= 1'b0;
			mem_b_wr <= 1'b0;
		end else begin
			mem_a_rd <= mmio_rd_valid && win_a_hit;
			mem_a_wr <= mmio_wr_valid && win_a_hit;
			mem_b_rd <= mmio_rd_valid && win_b_hit;
			mem_b_wr <= mmio_wr_valid && win_b_hit;
		end
	end

	always_ff @(posedge Clk_400) begin
		mem_index   <= mmio_addr[7:0];  // word within the window
		mem_wr_data <= mmio_wr_data;
	end

	// **************************************************
	// read response pipeline
	// **************************************************
	always_ff @(posedge Clk_400) begin
		if (reset) begin
			rd_vld            <= '0;
			mmio_rd_rsp_valid <= 1'b0;
		end else begin
			rd_vld            <= {rd_vld[RD_STAGES-2:0], mmio_rd_valid};
			mmio_rd_rsp_valid <= rd_vld[RD_STAGES-1];
		end
	end

	// bank data lands in the last stage, csr value rides along
	always_ff @(posedge Clk_400) begin
		rd_sel[0] <= rd_sel_now;
		rd_csr[0] <= csr_rd_val;
		for (int i = 1; i < RD_STAGES; i++) begin
			rd_sel[i] <= rd_sel[i-1];
			rd_csr[i] <= rd_csr[i-1];
		end
		case (rd_sel[RD_STAGES-1])
			afu_pkg::RSP_SEL_MEM_A: mmio_rd_rsp_data <= mem_a_rd_data;
			afu_pkg::RSP_SEL_MEM_B: mmio_rd_rsp_data <= mem_b_rd_data;
			default:                mmio_rd_rsp_data <= rd_csr[RD_STAGES-1];
		endcase
	end

	// host never reads and writes in one cycle
	a_one_strobe: assert property (@(posedge Clk_400) disable iff (reset)
		!(mmio_wr_valid && mmio_rd_valid));

	// engine must be idle whenever a start goes out
	a_start_idle: assert property (@(posedge Clk_400) disable iff (reset)
		start |-> !busy);

endmodule

// ==== hw/local_mem.sv ====
`timescale 1ns/1ps
// dual port local memory bank
module local_mem (
	input  logic                Clk_400,
	input  logic                reset,
	// port a
	input  logic                a_rd,
	input  logic                a_wr,
	input  afu_pkg::t_mem_addr  a_index,
	input  afu_pkg::t_mmio_data a_wr_data,
	output afu_pkg::t_mmio_data a_rd_data,
	// port b
	input  logic                b_rd,
	input  logic                b_wr,
	input  afu_pkg::t_mem_addr  b_index,
	input  afu_pkg::t_mmio_data b_wr_data,
	output afu_pkg::t_mmio_data b_rd_data
);

	afu_pkg::t_mmio_data mem [afu_pkg::MEM_DEPTH];  // contents undefined after reset

	afu_pkg::t_mmio_data a_stage;  // first read register
	afu_pkg::t_mmio_data b_stage;
	logic                a_stage_vld;
	logic                b_stage_vld;

	// write at the sampling edge, port b last
	always_ff @(posedge Clk_400) begin
		if (a_wr)
			mem[a_index] <= a_wr_data;
		if (b_wr)
			mem[b_index] <= b_wr_data;
	end

	// **************************************************
	// two stage read pipeline per port
	// **************************************************
	always_ff @(posedge Clk_400) begin
		if (a_rd)
			a_stage <= mem[a_index];  // old word on same cycle write
		if (b_rd)
			b_stage <= mem[b_index];
	end

	always_ff @(posedge Clk_400) begin
		if (reset) begin
			a_stage_vld <= 1'b0;
			b_stage_vld <= 1'b0;
		end else begin
			a_stage_vld <= a_rd;
			b_stage_vld <= b_rd;
		end
	end

	// output regs hold until the next read lands
	always_ff @(posedge Clk_400) begin
		if (a_stage_vld)
			a_rd_data <= a_stage;
		if (b_stage_vld)
			b_rd_data <= b_stage;
	end

	// both ports writing one word is a user error
	a_dual_write: assert property (@(posedge Clk_400) disable iff (reset)
		(a_wr && b_wr) |-> (a_index != b_index));

endmodule

// ==== hw/afu_pkg.sv ====
// afu shared types and address map
package afu_pkg;

	// **************************************************
	// vector types
	// **************************************************
	typedef logic [17:0] t_mmio_addr;  // mmio word address
	typedef logic [63:0] t_mmio_data;  // mmio and bank data word
	typedef logic [7:0]  t_mem_addr;   // bank word index
	typedef logic [8:0]  t_dma_len;    // copy length, 0 to 256 words
	typedef logic [1:0]  t_rsp_sel;    // read response source

	// copy engine states
	typedef enum logic [1:0] {
		DMA_IDLE  = 2'd0,  // waiting for start
		DMA_RUN   = 2'd1,  // one bank a read per cycle
		DMA_DRAIN = 2'd2   // reads done, returns still in flight
	} t_dma_state;

	// **************************************************
	// mmio address map
	// **************************************************
	localparam t_mmio_addr CSR_SRC      = 18'h00000;  // source index
	localparam t_mmio_addr CSR_DST      = 18'h00001;  // destination index
	localparam t_mmio_addr CSR_LEN      = 18'h00002;  // length in words
	localparam t_mmio_addr CSR_CTRL     = 18'h00003;  // bit 0 starts a copy
	localparam t_mmio_addr CSR_STATUS   = 18'h00004;  // bit 0 busy, bit 1 done sticky
	localparam t_mmio_addr CSR_CHECKSUM = 18'h00005;  // sum of copied words

	// 256 word windows, picked by addr[17:8]
	localparam t_mmio_addr WIN_A_BASE   = 18'h01000;
	localparam t_mmio_addr WIN_B_BASE   = 18'h02000;

	// read response mux select
	localparam t_rsp_sel RSP_SEL_CSR   = 2'd0;  // csr value or zero
	localparam t_rsp_sel RSP_SEL_MEM_A = 2'd1;
	localparam t_rsp_sel RSP_SEL_MEM_B = 2'd2;

	// **************************************************
	// latencies and sizes
	// **************************************************
	localparam int MEM_LATENCY     = 2;    // bank read strobe to data, cycles
	localparam int MMIO_RD_LATENCY = 3;    // sampled read to response, cycles
	localparam int MEM_DEPTH       = 256;  // words per bank

endpackage
